/* design/bitmanip_pkg.sv */
package bitmanip_pkg;

  localparam int OP_W = 5;  // opcode width

  // ----------------------------------------------------------
  // opcodes as presented by the core
  // ----------------------------------------------------------
  typedef enum logic [OP_W-1:0] {
    // Zbb logic with negate
    OP_ANDN   = 5'd0,
    OP_ORN    = 5'd1,
    OP_XNOR   = 5'd2,
    // Zbb counts
    OP_CLZ    = 5'd3,
    OP_CTZ    = 5'd4,
    OP_CPOP   = 5'd5,
    // Zbb min/max
    OP_MIN    = 5'd6,
    OP_MINU   = 5'd7,
    OP_MAX    = 5'd8,
    OP_MAXU   = 5'd9,
    // Zbb extensions
    OP_SEXTB  = 5'd10,
    OP_SEXTH  = 5'd11,
    OP_ZEXTH  = 5'd12,
    // Zbb rotates, shift amount from rs2
    OP_ROL    = 5'd13,
    OP_ROR    = 5'd14,
    // Zbb byte ops
    OP_ORCB   = 5'd15,
    OP_REV8   = 5'd16,
    // Zba shifted add
    OP_SH1ADD = 5'd17,
    OP_SH2ADD = 5'd18,
    OP_SH3ADD = 5'd19,
    // Zbs single bit
    OP_BCLR   = 5'd20,
    OP_BEXT   = 5'd21,
    OP_BINV   = 5'd22,
    OP_BSET   = 5'd23,
    // Zbc carry-less multiply, multi-cycle
    OP_CLMUL  = 5'd24,
    OP_CLMULH = 5'd25,
    OP_CLMULR = 5'd26
  } bitmanip_op_e;

  // controller states
  typedef enum logic [1:0] {
    S_IDLE        = 2'd0,  // waiting for start
    S_CLMUL_START = 2'd1,  // multiplier loads operands
    S_CLMUL_BUSY  = 2'd2   // multiplier iterating
  } ctrl_state_e;

endpackage

/* design/bitmanip_ctrl.sv */
`timescale 1ns/10ps

module bitmanip_ctrl import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // data width
) (
  input  logic            clk_i,
  input  logic            rstn_i,         // async, active low
  input  logic            start_i,        // request strobe from core
  input  bitmanip_op_e    op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic            clmul_busy_i,   // multiplier has more than one step left
  output bitmanip_op_e    op_o,           // registered opcode
  output logic [XLEN-1:0] rs1_o,          // registered operands
  output logic [XLEN-1:0] rs2_o,
  output logic            clmul_start_o,  // one-cycle load pulse to multiplier
  output logic            done_o          // selected result valid this cycle
);

  ctrl_state_e state_q;
  logic        accept;    // request taken this cycle
  logic        is_clmul;  // request needs the multiplier

  assign accept   = start_i && (state_q == S_IDLE);
  assign is_clmul = op_i inside {OP_CLMUL, OP_CLMULH, OP_CLMULR};

  // ----------------------------------------------------------
  // operand and opcode registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o  <= op_i;
      rs1_o <= rs1_i;
      rs2_o <= rs2_i;
    end
  end

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q       <= S_IDLE;
      clmul_start_o <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      clmul_start_o <= 1'b0;  // pulses by default
      done_o        <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            if (is_clmul) begin
              clmul_start_o <= 1'b1;
              state_q       <= S_CLMUL_START;
            end else begin
              done_o <= 1'b1;  // single-cycle ops finish right away
            end
          end
        end

        // multiplier picks up the operands on this edge
        S_CLMUL_START: begin
          state_q <= S_CLMUL_BUSY;
        end

        // busy drops one step early, so done meets the final product
        S_CLMUL_BUSY: begin
          if (!clmul_busy_i) begin
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end

        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // protocol checks
  // ----------------------------------------------------------
  // no back-pressure, core waits for valid_o before the next request
  a_start_idle : assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> (state_q == S_IDLE))
    else $error("start_i raised while state is %s", state_q.name());

  // multiplier must release within one operand width
  a_busy_bound : assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(clmul_busy_i) |-> ##[1:XLEN] !clmul_busy_i)
    else $error("clmul busy longer than %0d cycles", XLEN);

  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rstn_i)
    done_o |=> !done_o)
    else $error("done held for two cycles");

endmodule

/* design/bitmanip_shift_count.sv */
`timescale 1ns/10ps

module bitmanip_shift_count import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // data width
) (
  input  bitmanip_op_e    op_i,
  input  logic [XLEN-1:0] rs1_i,  // data operand
  input  logic [XLEN-1:0] rs2_i,  // low bits give rotate amount
  output logic [XLEN-1:0] res_o   // zero for foreign opcodes
);

  localparam int SW = $clog2(XLEN);  // shift amount bits
  localparam int CW = SW + 1;        // count bits, holds XLEN itself

  logic [SW-1:0]   shamt;
  logic [XLEN-1:0] rs1_rev;          // bit-reversed rs1
  logic [XLEN-1:0] lvl [SW:0];       // rotator stages, lvl[SW] is input
  logic [XLEN-1:0] rot_r;
  logic [XLEN-1:0] rot_l;
  logic [XLEN-1:0] lz_src;
  logic [CW-1:0]   lz_cnt;
  logic [CW-1:0]   pop_cnt;

  assign shamt   = rs2_i[SW-1:0];
  assign rs1_rev = {<<{rs1_i}};

  // ----------------------------------------------------------
  // barrel rotator, right only
  // ----------------------------------------------------------
  // left rotate = reverse, rotate right, reverse back
  assign lvl[SW] = (op_i == OP_ROL) ? rs1_rev : rs1_i;

  for (genvar i = SW - 1; i >= 0; i--) begin : g_rot
    assign lvl[i] = shamt[i] ? {lvl[i+1][2**i-1:0], lvl[i+1][XLEN-1:2**i]}  // ror by 2^i
                             : lvl[i+1];
  end

  assign rot_r = lvl[0];
  assign rot_l = {<<{rot_r}};

  // ----------------------------------------------------------
  // counters
  // ----------------------------------------------------------
  // trailing zeros are leading zeros of the reversed word
  assign lz_src = (op_i == OP_CTZ) ? rs1_rev : rs1_i;

  always_comb begin
    lz_cnt = CW'(XLEN);  // all zero
    for (int i = 0; i < XLEN; i++) begin
      if (lz_src[i]) begin
        lz_cnt = CW'(XLEN - 1 - i);  // highest set bit wins
      end
    end
  end

  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_cnt = pop_cnt + CW'(rs1_i[i]);
    end
  end

  // result select
  always_comb begin
    case (op_i)
      OP_ROR:         res_o = rot_r;
      OP_ROL:         res_o = rot_l;
      OP_CLZ, OP_CTZ: res_o = XLEN'(lz_cnt);
      OP_CPOP:        res_o = XLEN'(pop_cnt);
      default:        res_o = '0;
    endcase
  end

endmodule

/* design/bitmanip_clmul.sv */
`timescale 1ns/10ps

module bitmanip_clmul import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // data width
) (
  input  logic            clk_i,
  input  logic            rstn_i,   // async, active low
  input  logic            start_i,  // load operands, one-cycle pulse
  input  bitmanip_op_e    op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  output logic            busy_o,   // high until the last step is pending
  output logic [XLEN-1:0] res_o
);

  localparam int CW = $clog2(XLEN) + 1;

  logic [CW-1:0]     cnt_q;   // steps left
  logic [2*XLEN-1:0] prod_q;  // hi: partial sum, lo: multiplier bits shifting out
  logic              rev_en;  // clmulr works on reversed operands
  logic [XLEN-1:0]   rs1_rev;
  logic [XLEN-1:0]   rs2_rev;
  logic [XLEN-1:0]   opb;     // multiplicand
  logic [XLEN-1:0]   low_rev;

  assign rev_en  = (op_i == OP_CLMULR);
  assign rs1_rev = {<<{rs1_i}};
  assign rs2_rev = {<<{rs2_i}};
  assign opb     = rev_en ? rs2_rev : rs2_i;
  assign low_rev = {<<{prod_q[XLEN-1:0]}};

  // ----------------------------------------------------------
  // step counter
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CW'(XLEN);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q > CW'(1));  // falls with one step to go

  // ----------------------------------------------------------
  // shift-and-xor datapath
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      prod_q <= {{XLEN{1'b0}}, (rev_en ? rs1_rev : rs1_i)};
    end else if (cnt_q != '0) begin
      // xor multiplicand into upper half if lsb set, then shift right
      prod_q <= {1'b0,
                 prod_q[2*XLEN-1:XLEN] ^ (prod_q[0] ? opb : '0),
                 prod_q[XLEN-1:1]};
    end
  end

  always_comb begin
    case (op_i)
      OP_CLMUL:  res_o = prod_q[XLEN-1:0];
      OP_CLMULH: res_o = prod_q[2*XLEN-1:XLEN];
      OP_CLMULR: res_o = low_rev;  // rev(clmul(rev a, rev b))
      default:   res_o = '0;
    endcase
  end

  // controller must not reload while a product is still forming
  a_no_restart : assert property (@(posedge clk_i) disable iff (!rstn_i)
    start_i |-> !busy_o && (cnt_q == '0))
    else $error("clmul start while multiplier busy");

endmodule

/* design/bitmanip_alu.sv */
`timescale 1ns/10ps

module bitmanip_alu import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // data width
) (
  input  bitmanip_op_e    op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  output logic [XLEN-1:0] res_o  // zero for foreign opcodes
);

  localparam int SW = $clog2(XLEN);  // bit index width
  localparam int NB = XLEN / 8;      // bytes per word

  logic            lt_s;      // rs1 < rs2 signed
  logic            lt_u;      // rs1 < rs2 unsigned
  logic [XLEN-1:0] min_s;
  logic [XLEN-1:0] min_u;
  logic [XLEN-1:0] max_s;
  logic [XLEN-1:0] max_u;
  logic [XLEN-1:0] orcb;
  logic [XLEN-1:0] rev8;
  logic [XLEN-1:0] sh_opa;    // rs1 shifted by 1..3
  logic [XLEN-1:0] sh_sum;
  logic [XLEN-1:0] bit_mask;  // one-hot from rs2
  logic            bit_ext;

  // ----------------------------------------------------------
  // comparator for min/max
  // ----------------------------------------------------------
  assign lt_s  = $signed(rs1_i) < $signed(rs2_i);
  assign lt_u  = rs1_i < rs2_i;
  assign min_s = lt_s ? rs1_i : rs2_i;
  assign max_s = lt_s ? rs2_i : rs1_i;
  assign min_u = lt_u ? rs1_i : rs2_i;
  assign max_u = lt_u ? rs2_i : rs1_i;

  // ----------------------------------------------------------
  // byte ops
  // ----------------------------------------------------------
  for (genvar b = 0; b < NB; b++) begin : g_byte
    assign orcb[8*b +: 8] = {8{|rs1_i[8*b +: 8]}};    // any bit set -> 0xff
    assign rev8[8*b +: 8] = rs1_i[8*(NB-1-b) +: 8];   // mirror byte order
  end

  // shifted add, amount from opcode
  always_comb begin
    case (op_i)
      OP_SH1ADD: sh_opa = {rs1_i[XLEN-2:0], 1'b0};
      OP_SH2ADD: sh_opa = {rs1_i[XLEN-3:0], 2'b0};
      default:   sh_opa = {rs1_i[XLEN-4:0], 3'b0};  // sh3add
    endcase
  end

  assign sh_sum = rs2_i + sh_opa;

  // one-hot decoder for single-bit ops
  always_comb begin
    bit_mask = '0;
    bit_mask[rs2_i[SW-1:0]] = 1'b1;
  end

  assign bit_ext = |(rs1_i & bit_mask);

  // ----------------------------------------------------------
  // result select
  // ----------------------------------------------------------
  always_comb begin
    case (op_i)
      OP_ANDN:   res_o = rs1_i & ~rs2_i;
      OP_ORN:    res_o = rs1_i | ~rs2_i;
      OP_XNOR:   res_o = ~(rs1_i ^ rs2_i);
      OP_MIN:    res_o = min_s;
      OP_MINU:   res_o = min_u;
      OP_MAX:    res_o = max_s;
      OP_MAXU:   res_o = max_u;
      OP_SEXTB:  res_o = {{(XLEN-8){rs1_i[7]}}, rs1_i[7:0]};
      OP_SEXTH:  res_o = {{(XLEN-16){rs1_i[15]}}, rs1_i[15:0]};
      OP_ZEXTH:  res_o = {{(XLEN-16){1'b0}}, rs1_i[15:0]};
      OP_ORCB:   res_o = orcb;
      OP_REV8:   res_o = rev8;
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: begin
        res_o = sh_sum;
      end
      OP_BCLR:   res_o = rs1_i & ~bit_mask;
      OP_BEXT:   res_o = {{(XLEN-1){1'b0}}, bit_ext};
      OP_BINV:   res_o = rs1_i ^ bit_mask;
      OP_BSET:   res_o = rs1_i | bit_mask;
      default:   res_o = '0;  // rotate, count, clmul live elsewhere
    endcase
  end

endmodule

/* design/bitmanip_unit.sv */
`timescale 1ns/10ps

module bitmanip_unit import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // data width, multiple of 8
) (
  input  logic            clk_i,
  input  logic            rstn_i,   // async, active low
  input  logic            start_i,  // one-cycle request, only when idle
  input  bitmanip_op_e    op_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  output logic [XLEN-1:0] res_o,    // zero unless valid_o
  output logic            valid_o   // one-cycle result pulse
);

  bitmanip_op_e    op_q;
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;
  logic            clmul_start;
  logic            clmul_busy;
  logic            done;
  logic [XLEN-1:0] sc_res;   // rotate/count
  logic [XLEN-1:0] cm_res;   // carry-less multiply
  logic [XLEN-1:0] alu_res;  // everything else
  logic [XLEN-1:0] sel_res;

  // ----------------------------------------------------------
  // blocks
  // ----------------------------------------------------------
  bitmanip_ctrl #(.XLEN(XLEN)) u_ctrl (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_i       (start_i),
    .op_i          (op_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .clmul_busy_i  (clmul_busy),
    .op_o          (op_q),
    .rs1_o         (rs1_q),
    .rs2_o         (rs2_q),
    .clmul_start_o (clmul_start),
    .done_o        (done)
  );

  bitmanip_shift_count #(.XLEN(XLEN)) u_shift_count (
    .op_i  (op_q),
    .rs1_i (rs1_q),
    .rs2_i (rs2_q),
    .res_o (sc_res)
  );

  bitmanip_clmul #(.XLEN(XLEN)) u_clmul (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (clmul_start),
    .op_i    (op_q),
    .rs1_i   (rs1_q),
    .rs2_i   (rs2_q),
    .busy_o  (clmul_busy),
    .res_o   (cm_res)
  );

  bitmanip_alu #(.XLEN(XLEN)) u_alu (
    .op_i  (op_q),
    .rs1_i (rs1_q),
    .rs2_i (rs2_q),
    .res_o (alu_res)
  );

  // pick by opcode class
  always_comb begin
    case (op_q)
      OP_ROL, OP_ROR, OP_CLZ, OP_CTZ, OP_CPOP: sel_res = sc_res;
      OP_CLMUL, OP_CLMULH, OP_CLMULR:          sel_res = cm_res;
      default:                                 sel_res = alu_res;
    endcase
  end

  // output stage, cleared outside the valid cycle
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else begin
      res_o   <= done ? sel_res : '0;
      valid_o <= done;
    end
  end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0  // full clock period
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

/* sim/bitmanip_tb.sv */
`timescale 1ns/10ps

module bitmanip_tb import bitmanip_pkg::*; #(
  parameter int XLEN = 32  // passed to the DUT
);

  localparam int          NUM_OPS    = 600;
  localparam int unsigned MAX_CYCLES = NUM_OPS * (XLEN + 8) + 100;

  logic            clk;
  logic            rstn;
  logic            start;
  bitmanip_op_e    op;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] res;
  logic            valid;
  int unsigned     cycle_cnt = 0;
  bitmanip_op_e    cur_op;      // op in flight for error lines
  logic [XLEN-1:0] cur_a;
  logic [XLEN-1:0] cur_b;

  tb_clk_gen #(.PERIOD_NS(4.0)) u_clk_gen (.clk_o(clk));

  bitmanip_unit #(.XLEN(XLEN)) dut_i (
    .clk_i   (clk),
    .rstn_i  (rstn),
    .start_i (start),
    .op_i    (op),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .res_o   (res),
    .valid_o (valid)
  );

  // ----------------------------------------------------------
  // error handling and compare tasks
  // ----------------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t %s got=%h exp=%h (op %s rs1=%h rs2=%h)",
                              $time, name, got, exp, cur_op.name(), cur_a, cur_b));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  // edges from the sampling edge up to valid_o
  task automatic compare_latency(input bitmanip_op_e o, input int unsigned got);
    int unsigned exp;
    exp = (o inside {OP_CLMUL, OP_CLMULH, OP_CLMULR}) ? XLEN + 3 : 2;
    if (got != exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t latency got=%0d exp=%0d (op %s)",
                              $time, got, exp, o.name()));
    end
  endtask

  // ----------------------------------------------------------
  // reference model from the ISA rules
  // ----------------------------------------------------------
  function automatic logic [XLEN-1:0] ref_result(input bitmanip_op_e o,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [XLEN-1:0]   r;
    logic [2*XLEN-1:0] p;    // full carry-less product
    int unsigned       sh;   // rs2 mod XLEN
    int unsigned       k;
    r  = '0;
    p  = '0;
    k  = 0;
    sh = b % XLEN;
    for (int i = 0; i < XLEN; i++) begin
      if (b[i]) p = p ^ ((2*XLEN)'(a) << i);
    end
    case (o)
      OP_ANDN:   r = a & ~b;
      OP_ORN:    r = a | ~b;
      OP_XNOR:   r = ~(a ^ b);
      OP_CLZ: begin
        while (k < XLEN && !a[XLEN-1-k]) k++;
        r = XLEN'(k);
      end
      OP_CTZ: begin
        while (k < XLEN && !a[k]) k++;
        r = XLEN'(k);
      end
      OP_CPOP: begin
        for (int i = 0; i < XLEN; i++) k += 32'(a[i]);
        r = XLEN'(k);
      end
      OP_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      OP_MINU:   r = (a < b) ? a : b;
      OP_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
      OP_MAXU:   r = (a < b) ? b : a;
      OP_SEXTB:  r = XLEN'($signed(a[7:0]));
      OP_SEXTH:  r = XLEN'($signed(a[15:0]));
      OP_ZEXTH:  r = XLEN'(a[15:0]);
      OP_ROL:    for (int i = 0; i < XLEN; i++) r[(i + sh) % XLEN] = a[i];
      OP_ROR:    for (int i = 0; i < XLEN; i++) r[i] = a[(i + sh) % XLEN];
      OP_ORCB: begin
        for (int i = 0; i < XLEN / 8; i++) begin
          r[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
        end
      end
      OP_REV8:   for (int i = 0; i < XLEN / 8; i++) r[8*i +: 8] = a[XLEN-8-8*i +: 8];
      OP_SH1ADD: r = (a << 1) + b;
      OP_SH2ADD: r = (a << 2) + b;
      OP_SH3ADD: r = (a << 3) + b;
      OP_BCLR:   r = a & ~(XLEN'(1) << sh);
      OP_BEXT:   r = XLEN'(a[sh]);
      OP_BINV:   r = a ^ (XLEN'(1) << sh);
      OP_BSET:   r = a | (XLEN'(1) << sh);
      OP_CLMUL:  r = p[XLEN-1:0];
      OP_CLMULH: r = p[2*XLEN-1:XLEN];
      OP_CLMULR: for (int i = 0; i < XLEN; i++) if (b[i]) r = r ^ (a >> (XLEN - i - 1));
      default:   r = '0;
    endcase
    return r;
  endfunction

  // zero, all ones and single bits show up often
  function automatic logic [XLEN-1:0] rand_operand();
    logic [XLEN-1:0] v;
    case ($urandom % 6)
      0:       v = '0;
      1:       v = '1;
      2:       v = XLEN'(1) << ($urandom % XLEN);
      default: v = XLEN'({$urandom, $urandom});
    endcase
    return v;
  endfunction

  // ----------------------------------------------------------
  // one request entered 1 ns after a rising edge
  // ----------------------------------------------------------
  task automatic run_op(input bitmanip_op_e o, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
    logic [XLEN-1:0] exp;
    int unsigned     lat;
    exp    = ref_result(o, a, b);
    cur_op = o;
    cur_a  = a;
    cur_b  = b;
    start  = 1'b1;
    op     = o;
    rs1    = a;
    rs2    = b;
    lat    = 0;
    do begin
      @(posedge clk);
      #1;
      lat++;
      start = 1'b0;
      rs1   = ~a;  // operands must already be registered
      rs2   = ~b;
      if (!valid) compare_word("res_o", res, '0);  // cleared outside valid
    end while (!valid);
    compare_latency(o, lat);
    compare_word("res_o", res, exp);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    bitmanip_op_e o;
    void'($urandom(32'h21cb));
    rstn  = 1'b0;
    start = 1'b0;
    op    = OP_ANDN;
    rs1   = '0;
    rs2   = '0;
    repeat (5) @(posedge clk);
    #1 rstn = 1'b1;
    repeat (3) begin  // idle after reset
      compare_bit("valid_o", valid, 1'b0);
      compare_word("res_o", res, '0);
      @(posedge clk);
      #1;
    end
    // corner cases for the counters and rotator
    run_op(OP_CLZ, '0, '0);
    run_op(OP_CTZ, '0, '0);
    run_op(OP_CPOP, '0, '0);
    run_op(OP_ROL, rand_operand(), '0);
    run_op(OP_ROR, rand_operand(), '0);
    run_op(OP_CLMULR, '1, '1);
    // random mix back to back
    for (int n = 0; n < NUM_OPS; n++) begin
      o = bitmanip_op_e'($urandom % 27);
      run_op(o, rand_operand(), rand_operand());
    end
    @(posedge clk);
    #1;
    compare_bit("valid_o", valid, 1'b0);  // pulse is a single cycle
    compare_word("res_o", res, '0);
    $display("Testbench passed");
    $finish;
  end

  // hang guard
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout after %0d cycles, controller in %s",
                              cycle_cnt, dut_i.u_ctrl.state_q.name()));
    end
  end

endmodule

/* flist.f */
design/bitmanip_pkg.sv
design/bitmanip_ctrl.sv
design/bitmanip_shift_count.sv
design/bitmanip_clmul.sv
design/bitmanip_alu.sv
design/bitmanip_unit.sv
sim/tb_clk_gen.sv
sim/bitmanip_tb.sv

/* Makefile */
# Verilator build and run for the bit-manipulation unit

VERILATOR ?= verilator
TOP       ?= bitmanip_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

# the simulator exits non-zero on $$fatal, so make fails with it
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
